/* logic/lvds_rx_cfg.svh */
`ifndef LVDS_RX_CFG_SVH
`define LVDS_RX_CFG_SVH

// sensor word and frame format
`define LVDS_RX_SERDES_W    6       // bits per deserializer word
`define LVDS_RX_FRAME_W     12      // start bit + 10 data bits + stop bit
`define LVDS_RX_PIXEL_W     10      // bits per pixel

// bitslip training
`define LVDS_RX_SLIP_STATES 6       // deserializer bitslip has 6 unique positions
`define LVDS_RX_EVAL_DIV_W  4       // frame edges judged once per 16 frames

// phase alignment
`define LVDS_RX_PD_LIMIT    15      // votes needed beyond this for one tap step
`define LVDS_RX_TAP_LIMIT   31      // delay range in taps each way from center

// clock skew stepping
`define LVDS_RX_HOLDOFF_W   12      // hold-off saturates at 4095 cycles

`endif

/* logic/align_pkg.sv */
`include "lvds_rx_cfg.svh"

package align_pkg;

    // word and frame path types
    typedef logic [`LVDS_RX_SERDES_W-1:0]   serdes_word_t;  // one deserializer word
    typedef logic [`LVDS_RX_FRAME_W-1:0]    frame_t;        // two words, one full frame
    typedef logic [`LVDS_RX_PIXEL_W-1:0]    pixel_t;        // payload of one frame

    // bitslip position, 0 .. SLIP_STATES-1
    typedef logic [$clog2(`LVDS_RX_SLIP_STATES)-1:0] slip_cnt_t;

    typedef logic [`LVDS_RX_EVAL_DIV_W-1:0] eval_div_t;     // frames between evaluations

endpackage

/* logic/phase_pkg.sv */
`include "lvds_rx_cfg.svh"

package phase_pkg;

    // filter holds -15 .. +15, one spare bit for sign
    typedef logic signed [4:0]  pd_filter_t;

    // delay taps from center, +-31 used
    typedef logic signed [7:0]  tap_cnt_t;

    // net clock skew steps taken since iod_rst
    typedef logic signed [7:0]  skew_cnt_t;

    typedef logic [`LVDS_RX_HOLDOFF_W-1:0] holdoff_t;   // counts up and sticks at all ones

endpackage

/* logic/tap_limit_if.sv */
`timescale 1ns/10ps

interface tap_limit_if;

    logic req;          // filtered tap request pending
    logic req_inc;      // pending request is an increment
    logic at_max;       // delay at +31 taps
    logic at_min;       // delay at -31 taps

    // delay tracker side
    modport drv (
        output req, req_inc, at_max, at_min
    );

    // skew controller side
    modport mon (
        input  req, req_inc, at_max, at_min
    );

endinterface

/* logic/word_align.sv */
`timescale 1ns/10ps
`include "lvds_rx_cfg.svh"

module word_align (
    input  logic                    clk_2x,
    input  logic                    rst_2x,
    input  align_pkg::serdes_word_t is_data,        // newest word from deserializer
    output align_pkg::pixel_t       data,           // captured pixel
    output logic                    data_valid,     // one pulse per frame
    output logic                    train_done,     // frame edges locked
    output logic                    is_bitslip      // single cycle slip request
);

    // frame with only the start bit set as sent by the sensor while training
    localparam align_pkg::frame_t train_pat = align_pkg::frame_t'(1);

    align_pkg::frame_t      frame;          // shift register with the newest word on top
    logic                   xfer_en;        // marks a complete frame in the shifter
    logic                   word_slip;      // hold xfer_en one cycle
    align_pkg::eval_div_t   eval_div;       // counts enabled frames
    logic                   eval_pulse;     // once every 16 frames
    logic                   mismatch;       // bad start or stop bit seen
    logic                   mask;           // ignore frames until slip settles
    align_pkg::slip_cnt_t   slip_cnt;       // deserializer bitslip position
    logic                   edge_bad;
    logic                   slip_wrap;

    assign edge_bad  = (frame[`LVDS_RX_FRAME_W-1] != 1'b0) || (frame[0] != 1'b1);   // bad stop or start
    assign slip_wrap = (slip_cnt == align_pkg::slip_cnt_t'(`LVDS_RX_SLIP_STATES - 1));

    // two words per frame with the oldest bits at the bottom
    always_ff @(posedge clk_2x) begin
        frame <= {is_data, frame[`LVDS_RX_FRAME_W-1:`LVDS_RX_SERDES_W]};
    end

    // frame boundary every second word and one word later after a word slip
    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            xfer_en <= 1'b0;
        end else if (!word_slip) begin
            xfer_en <= !xfer_en;
        end
    end

    // pixel sits between start and stop bit
    always_ff @(posedge clk_2x) begin
        if (xfer_en) begin
            data <= frame[`LVDS_RX_PIXEL_W:1];     // payload bits only
        end
    end

    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= xfer_en;                  // tracks the data update
        end
    end

    // evaluation strobe one cycle after the 16th enabled frame
    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            eval_div   <= '0;
            eval_pulse <= 1'b0;
        end else begin
            if (xfer_en) begin
                eval_div <= eval_div + 1'b1;
            end
            eval_pulse <= (&eval_div) && xfer_en;
        end
    end

    // edge check and training pattern detect
    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            mismatch   <= 1'b0;
            mask       <= 1'b1;                     // nothing judged before first eval
            train_done <= 1'b0;
        end else begin
            if (xfer_en && !mask) begin
                if (edge_bad) begin
                    mismatch   <= 1'b1;
                    train_done <= 1'b0;
                end
                if (frame == train_pat) begin
                    train_done <= 1'b1;             // edges and payload both right
                end
            end
            // a slip restarts the judgement because frames in flight are stale
            if (is_bitslip) begin
                mismatch   <= 1'b0;
                mask       <= 1'b1;
                train_done <= 1'b0;
            end
            if (eval_pulse) begin
                mask <= 1'b0;
            end
        end
    end

    // six bit slips and then one whole word slip
    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            is_bitslip <= 1'b0;
            word_slip  <= 1'b0;
            slip_cnt   <= '0;
        end else begin
            is_bitslip <= 1'b0;                     // pulse
            word_slip  <= 1'b0;
            if (eval_pulse && mismatch) begin
                is_bitslip <= 1'b1;
                if (slip_wrap) begin
                    // deserializer is back where it started so move a word instead
                    slip_cnt  <= '0;
                    word_slip <= 1'b1;
                end else begin
                    slip_cnt <= slip_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/phase_align.sv */
`timescale 1ns/10ps
`include "lvds_rx_cfg.svh"

module phase_align (
    input  logic                clk_2x,
    input  logic                rst_2x,
    input  logic                iod_rst,        // recenters the tap tracking
    input  logic                pd_valid,       // phase detector vote present
    input  logic                pd_incdec,      // vote direction, 1 = increment
    input  logic                iod_busy,       // delay still applying last step
    input  logic                iod_mask,       // external hold on tap changes
    output logic                iod_ce,
    output logic                iod_inc,
    output phase_pkg::tap_cnt_t iod_cnt,        // taps from center
    tap_limit_if.drv            lim
);

    phase_pkg::pd_filter_t  pd_filter;      // running vote balance
    logic                   req_q;          // one tap step pending
    logic                   req_inc_q;      // direction of pending step
    logic                   filt_max;
    logic                   filt_min;
    logic                   tap_max;
    logic                   tap_min;
    logic                   vote_ok;

    assign filt_max = (pd_filter == phase_pkg::pd_filter_t'(`LVDS_RX_PD_LIMIT));    // +15
    assign filt_min = (pd_filter == -phase_pkg::pd_filter_t'(`LVDS_RX_PD_LIMIT));   // -15

    assign tap_max = (iod_cnt == phase_pkg::tap_cnt_t'(`LVDS_RX_TAP_LIMIT));        // +31
    assign tap_min = (iod_cnt == -phase_pkg::tap_cnt_t'(`LVDS_RX_TAP_LIMIT));       // -31

    // votes only count while the delay path is idle
    assign vote_ok = pd_valid && !req_q && !iod_busy && !iod_mask;

    // vote filter, 16th vote in a row from zero raises a request
    always_ff @(posedge clk_2x) begin
        if (rst_2x) begin
            pd_filter <= '0;
            req_q     <= 1'b0;
            req_inc_q <= 1'b0;
        end else begin
            if (iod_busy) begin
                req_q     <= 1'b0;              // delay took the step
                req_inc_q <= 1'b0;
            end
            if (vote_ok) begin
                if (pd_incdec) begin
                    if (filt_max) begin
                        pd_filter <= '0;
                        req_q     <= 1'b1;
                        req_inc_q <= 1'b1;
                    end else begin
                        pd_filter <= pd_filter + 1'b1;
                    end
                end else begin
                    if (filt_min) begin
                        pd_filter <= '0;
                        req_q     <= 1'b1;
                        req_inc_q <= 1'b0;
                    end else begin
                        pd_filter <= pd_filter - 1'b1;
                    end
                end
            end
        end
    end

    // no step past the tap range, request stays pending for skew control
    assign iod_ce  = req_q && (!tap_max || !req_inc_q) && (!tap_min || req_inc_q);
    assign iod_inc = req_inc_q && iod_ce;

    // tap position follows every accepted step
    always_ff @(posedge clk_2x) begin
        if (iod_rst) begin
            iod_cnt <= '0;
        end else if (iod_ce && !iod_busy) begin
            if (iod_inc) begin
                iod_cnt <= iod_cnt + 1'b1;
            end else begin
                iod_cnt <= iod_cnt - 1'b1;
            end
        end
    end

    assign lim.req     = req_q;
    assign lim.req_inc = req_inc_q;
    assign lim.at_max  = tap_max;
    assign lim.at_min  = tap_min;

endmodule

/* logic/skew_ctrl.sv */
`timescale 1ns/10ps

module skew_ctrl (
    input  logic                    clk_2x,
    input  logic                    iod_rst,        // clears skew state with the taps
    input  logic                    skew_inhibit,   // external hold on skew steps
    input  logic                    skew_ack,       // clock generator took the step
    output logic                    skew_en,        // step request, level until ack
    output logic                    skew_inc,       // step direction
    output phase_pkg::skew_cnt_t    skew_cnt,       // net steps taken
    tap_limit_if.mon                lim
);

    phase_pkg::holdoff_t    holdoff;        // cycles since reset or last ack
    logic                   holdoff_done;
    logic                   push_up;        // wants a tap past +31
    logic                   push_dn;        // wants a tap past -31
    logic                   step_ok;

    assign holdoff_done = &holdoff;
    assign push_up      = lim.req && lim.req_inc && lim.at_max;
    assign push_dn      = lim.req && !lim.req_inc && lim.at_min;
    assign step_ok      = holdoff_done && !skew_en && !skew_ack && !skew_inhibit;

    always_ff @(posedge clk_2x) begin
        if (iod_rst) begin
            holdoff  <= '0;
            skew_en  <= 1'b0;
            skew_inc <= 1'b0;
            skew_cnt <= '0;
        end else begin
            if (!holdoff_done) begin
                holdoff <= holdoff + 1'b1;      // sticks at max
            end

            // drop request on ack and start the hold-off again
            if (skew_ack) begin
                skew_en  <= 1'b0;
                skew_inc <= 1'b0;
                holdoff  <= '0;
            end

            // move the clock when the delay has no range left
            if (step_ok) begin
                if (push_up) begin
                    skew_en  <= 1'b1;
                    skew_inc <= 1'b1;
                    skew_cnt <= skew_cnt + 1'b1;
                end else if (push_dn) begin
                    skew_en  <= 1'b1;
                    skew_inc <= 1'b0;
                    skew_cnt <= skew_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* logic/lvds_rx_top.sv */
`timescale 1ns/10ps

module lvds_rx_top (
    input  logic                    clk_2x,
    input  logic                    rst_2x,
    input  logic                    iod_rst,        // delay and skew recenter

    // deserializer
    input  align_pkg::serdes_word_t is_data,
    output logic                    is_bitslip,
    input  logic                    pd_valid,
    input  logic                    pd_incdec,

    // input delay
    output logic                    iod_ce,
    output logic                    iod_inc,
    input  logic                    iod_busy,
    input  logic                    iod_mask,
    output phase_pkg::tap_cnt_t     iod_cnt,        // debug, taps from center

    // pixel output
    output align_pkg::pixel_t       data,
    output logic                    data_valid,
    output logic                    train_done,

    // clock skew
    input  logic                    skew_inhibit,
    output logic                    skew_en,
    output logic                    skew_inc,
    input  logic                    skew_ack,
    output phase_pkg::skew_cnt_t    skew_cnt        // debug, net skew steps
);

    tap_limit_if lim_if ();             // tap request and limit flags

    word_align i_word_align (
        .clk_2x     (clk_2x),
        .rst_2x     (rst_2x),
        .is_data    (is_data),
        .data       (data),
        .data_valid (data_valid),
        .train_done (train_done),
        .is_bitslip (is_bitslip)
    );

    phase_align i_phase_align (
        .clk_2x     (clk_2x),
        .rst_2x     (rst_2x),
        .iod_rst    (iod_rst),
        .pd_valid   (pd_valid),
        .pd_incdec  (pd_incdec),
        .iod_busy   (iod_busy),
        .iod_mask   (iod_mask),
        .iod_ce     (iod_ce),
        .iod_inc    (iod_inc),
        .iod_cnt    (iod_cnt),
        .lim        (lim_if.drv)
    );

    skew_ctrl i_skew_ctrl (
        .clk_2x       (clk_2x),
        .iod_rst      (iod_rst),
        .skew_inhibit (skew_inhibit),
        .skew_ack     (skew_ack),
        .skew_en      (skew_en),
        .skew_inc     (skew_inc),
        .skew_cnt     (skew_cnt),
        .lim          (lim_if.mon)
    );

endmodule

/* test/lvds_rx_checker.sv */
`timescale 1ns/10ps
`include "lvds_rx_cfg.svh"

module lvds_rx_checker (
    input logic                 clk_2x,
    input logic                 rst_2x,
    input logic                 iod_rst,
    input logic                 is_bitslip,
    input logic                 iod_ce,
    input logic                 iod_busy,
    input phase_pkg::tap_cnt_t  iod_cnt,
    input logic                 skew_en,
    input logic                 skew_inc,
    input logic                 skew_ack
);

    int assert_fails = 0;       // failed assertions so far

    slip_single: assert property (@(posedge clk_2x) disable iff (rst_2x)
        is_bitslip |=> !is_bitslip)
        else begin
            $error("is_bitslip high two cycles in a row");
            assert_fails++;
        end

    // the delay going busy clears the pending step
    ce_drops_on_busy: assert property (@(posedge clk_2x) disable iff (rst_2x)
        iod_busy |=> !iod_ce)
        else begin
            $error("iod_ce still high after iod_busy");
            assert_fails++;
        end

    skew_inc_needs_en: assert property (@(posedge clk_2x) disable iff (iod_rst)
        skew_inc |-> skew_en)
        else begin
            $error("skew_inc high without skew_en");
            assert_fails++;
        end

    // only the ack may drop the request level
    skew_en_held: assert property (@(posedge clk_2x) disable iff (iod_rst)
        skew_en && !skew_ack |=> skew_en)
        else begin
            $error("skew_en dropped before skew_ack");
            assert_fails++;
        end

    tap_in_range: assert property (@(posedge clk_2x) disable iff (iod_rst)
        (iod_cnt <= phase_pkg::tap_cnt_t'(`LVDS_RX_TAP_LIMIT))
        && (iod_cnt >= -phase_pkg::tap_cnt_t'(`LVDS_RX_TAP_LIMIT)))
        else begin
            $error("iod_cnt outside the tap range");
            assert_fails++;
        end

endmodule

bind lvds_rx_top lvds_rx_checker i_checker (
    .clk_2x     (clk_2x),
    .rst_2x     (rst_2x),
    .iod_rst    (iod_rst),
    .is_bitslip (is_bitslip),
    .iod_ce     (iod_ce),
    .iod_busy   (iod_busy),
    .iod_cnt    (iod_cnt),
    .skew_en    (skew_en),
    .skew_inc   (skew_inc),
    .skew_ack   (skew_ack)
);

/* test/lvds_rx_tb.sv */
`timescale 1ns/10ps
`include "lvds_rx_cfg.svh"

module lvds_rx_tb;

    localparam int frame_w   = `LVDS_RX_FRAME_W;
    localparam int px_len    = 64;                          // pixels in the data burst
    localparam int train_max = 12 * 64;                     // 12 slip positions, 64 cycles each
    localparam int tap_max   = `LVDS_RX_TAP_LIMIT;
    localparam int holdoff   = 1 << `LVDS_RX_HOLDOFF_W;     // 4095 count plus register stage
    localparam int test_cycles = 8 + train_max + 128 + 2 * px_len + 100 + 300
                               + 33 * 30 + 3 * (holdoff + 100);
    localparam int watchdog_cycles = 12 * test_cycles;

    logic clk_2x, rst_2x, iod_rst, pd_valid, pd_incdec, iod_busy, iod_mask;
    logic skew_inhibit, skew_ack, is_bitslip, iod_ce, iod_inc, data_valid, train_done;
    logic skew_en, skew_inc;
    align_pkg::serdes_word_t is_data;
    align_pkg::pixel_t       data;
    phase_pkg::tap_cnt_t     iod_cnt;
    phase_pkg::skew_cnt_t    skew_cnt;

    logic [31:0]       rng_state;
    int unsigned       rd_pos;          // stream bit offset of the next word
    int unsigned       slip_total;      // bitslips seen by the deserializer model
    int unsigned       px_start;        // stream frame carrying px_mem[0]
    align_pkg::pixel_t px_mem [px_len];
    int                busy_cnt;
    bit                acc_pending;     // delay takes a step at the coming edge
    int                acc_cnt;         // tap steps taken by the delay model
    int                inc_cnt;
    int                errors;
    int                checks;

    lvds_rx_top i_dut (
        .clk_2x (clk_2x), .rst_2x (rst_2x), .iod_rst (iod_rst),
        .is_data (is_data), .is_bitslip (is_bitslip),
        .pd_valid (pd_valid), .pd_incdec (pd_incdec),
        .iod_ce (iod_ce), .iod_inc (iod_inc), .iod_busy (iod_busy),
        .iod_mask (iod_mask), .iod_cnt (iod_cnt),
        .data (data), .data_valid (data_valid), .train_done (train_done),
        .skew_inhibit (skew_inhibit), .skew_en (skew_en), .skew_inc (skew_inc),
        .skew_ack (skew_ack), .skew_cnt (skew_cnt)
    );

    initial begin
        clk_2x = 1'b0;
        forever #5 clk_2x = ~clk_2x;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // sensor line, LSB first: start 1, pixel bits 0..9, stop 0
    function automatic logic stream_bit(input int unsigned pos);
        int unsigned       f;
        int unsigned       j;
        align_pkg::pixel_t pix;
        f   = pos / frame_w;
        j   = pos % frame_w;
        pix = '0;                                           // training frames carry zero
        if (f >= px_start && f < px_start + px_len) begin
            pix = px_mem[f - px_start];
        end
        if (j == 0) begin
            return 1'b1;
        end else if (j == frame_w - 1) begin
            return 1'b0;
        end
        return pix[j - 1];
    endfunction

    // deserializer and input delay models
    always @(posedge clk_2x) begin
        #1;
        if (is_bitslip) begin
            if (slip_total % 6 == 5) begin
                rd_pos = rd_pos - 5;                        // bit position wraps after six
            end else begin
                rd_pos = rd_pos + 1;
            end
            slip_total++;
        end
        for (int k = 0; k < `LVDS_RX_SERDES_W; k++) begin
            is_data[k] = stream_bit(rd_pos + k);
        end
        rd_pos = rd_pos + `LVDS_RX_SERDES_W;
        if (acc_pending) begin
            busy_cnt = 3;                                   // busy from the cycle after the step
        end else if (busy_cnt != 0) begin
            busy_cnt--;
        end
        iod_busy    = (busy_cnt != 0);
        acc_pending = iod_ce && !iod_busy;
        if (acc_pending) begin
            acc_cnt++;
            if (iod_inc) inc_cnt++;
        end
    end

    task automatic tick();
        @(posedge clk_2x);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) tick();
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s exp 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    task automatic fail(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic send_votes(input int n, input logic dir);
        for (int i = 0; i < n; i++) begin
            tick();
            pd_valid  = 1'b1;
            pd_incdec = dir;
        end
        tick();
        pd_valid = 1'b0;
    endtask

    task automatic apply_reset();
        wait_cycles(8);
        check_val("is_bitslip", 0, is_bitslip);             // still in reset here
        check_val("data_valid", 0, data_valid);
        check_val("train_done", 0, train_done);
        check_val("iod_ce", 0, iod_ce);
        check_val("skew_en", 0, skew_en);
        check_val("iod_cnt", 0, iod_cnt);
        check_val("skew_cnt", 0, skew_cnt);
        rst_2x  = 1'b0;
        iod_rst = 1'b0;
    endtask

    task automatic train_frames();
        int n;
        int pulses;
        n      = 0;
        pulses = 0;
        while (!train_done && n < train_max) begin
            tick();
            n++;
            if (is_bitslip) pulses++;
        end
        if (!train_done) fail("train_done did not rise within the training window");
        if (pulses >= 12) fail("training took twelve or more bitslips");
        pulses = 0;
        for (int i = 0; i < 128; i++) begin
            tick();
            if (is_bitslip) pulses++;
            if (!train_done) n = -1;
        end
        if (n < 0) fail("train_done dropped after training");
        check_val("is_bitslip count after training", 0, pulses);
    endtask

    task automatic stream_pixels();
        logic [31:0] r;
        int          n;
        for (int k = 0; k < px_len; k++) begin
            r         = next_rand();
            px_mem[k] = r[`LVDS_RX_PIXEL_W-1:0];
        end
        if (px_mem[0] == '0) px_mem[0] = 1;                 // must differ from training frames
        @(negedge clk_2x);
        px_start = rd_pos / frame_w + 4;                    // a few frames ahead of the reader
        n = 0;
        do begin
            tick();
            n++;
        end while (!(data_valid && data === px_mem[0]) && n < 200);
        if (n >= 200) fail("first pixel of the burst never appeared on data");
        for (int k = 1; k < px_len && n < 200; k++) begin
            tick();
            if (!data_valid) tick();
            check_val("data", px_mem[k], data);
        end
    endtask

    task automatic vote_filter();
        int a0;
        int i0;
        int c0;
        a0 = acc_cnt;
        i0 = inc_cnt;
        c0 = iod_cnt;
        send_votes(16, 1'b1);
        wait_cycles(10);
        check_val("iod_ce count", a0 + 1, acc_cnt);
        check_val("iod_inc count", i0 + 1, inc_cnt);
        check_val("iod_cnt", c0 + 1, iod_cnt);
        iod_mask = 1'b1;
        send_votes(16, 1'b1);
        wait_cycles(10);
        iod_mask = 1'b0;
        check_val("iod_ce count masked", a0 + 1, acc_cnt);
        send_votes(15, 1'b1);
        send_votes(1, 1'b0);
        send_votes(14, 1'b0);                               // brings the filter back to zero
        wait_cycles(10);
        check_val("iod_ce count 15 up 1 down", a0 + 1, acc_cnt);
    endtask

    task automatic push_tap_limit();
        int  a0;
        int  n;
        time t_rst;
        iod_rst = 1'b1;
        wait_cycles(2);
        iod_rst = 1'b0;
        t_rst   = $time;
        for (int i = 0; i < tap_max; i++) begin
            send_votes(16, 1'b1);
            wait_cycles(6);
        end
        check_val("iod_cnt", tap_max, iod_cnt);
        a0 = acc_cnt;
        send_votes(16, 1'b1);
        wait_cycles(10);
        check_val("iod_ce count at limit", a0, acc_cnt);
        check_val("iod_cnt", tap_max, iod_cnt);
        check_val("skew_en", 0, skew_en);                   // hold-off still running
        n = 0;
        while (!skew_en && n < holdoff + 100) begin
            tick();
            n++;
        end
        if (!skew_en) fail("skew_en never rose after the hold-off");
        check_val("skew_en delay", holdoff, ($time - t_rst) / 10);
        check_val("skew_inc", 1, skew_inc);
        check_val("skew_cnt", 1, skew_cnt);
        skew_ack     = 1'b1;
        skew_inhibit = 1'b1;
        tick();
        skew_ack = 1'b0;
        check_val("skew_en", 0, skew_en);
        n = 0;
        for (int i = 0; i < holdoff + 50; i++) begin
            tick();
            if (skew_en) n++;
        end
        check_val("skew_en cycles while inhibited", 0, n);
        skew_inhibit = 1'b0;
        n = 0;
        while (!skew_en && n < 4) begin
            tick();
            n++;
        end
        check_val("skew_en", 1, skew_en);
        check_val("skew_inc", 1, skew_inc);
        check_val("skew_cnt", 2, skew_cnt);
        skew_ack = 1'b1;
        tick();
        skew_ack = 1'b0;
        check_val("skew_en", 0, skew_en);
    endtask

    initial begin
        int total;
        rng_state    = 32'd12;
        errors       = 0;
        checks       = 0;
        rst_2x       = 1'b1;
        iod_rst      = 1'b1;
        is_data      = '0;
        pd_valid     = 1'b0;
        pd_incdec    = 1'b0;
        iod_busy     = 1'b0;
        iod_mask     = 1'b0;
        skew_inhibit = 1'b0;
        skew_ack     = 1'b0;
        busy_cnt     = 0;
        acc_cnt      = 0;
        inc_cnt      = 0;
        slip_total   = 0;
        px_start     = 32'hffff_0000;                       // no pixel burst yet
        rd_pos       = next_rand() % frame_w;               // random frame phase
        apply_reset();
        train_frames();
        stream_pixels();
        vote_filter();
        push_tap_limit();
        tick();
        total = errors + i_dut.i_checker.assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, i_dut.i_checker.assert_fails);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_2x);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* lvds_rx.f */
+incdir+logic
logic/align_pkg.sv
logic/phase_pkg.sv
logic/tap_limit_if.sv
logic/word_align.sv
logic/phase_align.sv
logic/skew_ctrl.sv
logic/lvds_rx_top.sv
test/lvds_rx_checker.sv
test/lvds_rx_tb.sv

/* Bender.yml */
package:
  name: lvds_rx

sources:
  - include_dirs:
      - logic
    files:
      - logic/align_pkg.sv
      - logic/phase_pkg.sv
      - logic/tap_limit_if.sv
      - logic/word_align.sv
      - logic/phase_align.sv
      - logic/skew_ctrl.sv
      - logic/lvds_rx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/lvds_rx_checker.sv
      - test/lvds_rx_tb.sv
